//--- i2c_bridge_top.f
common/i2c_bridge_pkg.sv
i2c_bridge/i2c_cmd_sequencer.sv
i2c_bridge/i2c_bit_timer.sv
i2c_bridge/i2c_byte_engine.sv
verilog/i2c_bridge_top.sv
test/i2c_slave_model.sv
test/i2c_bridge_properties.sv
test/tb_i2c_bridge.sv

//--- Makefile
VERILATOR ?= verilator
TB_TOP    ?= tb_i2c_bridge
RTL_TOP   ?= i2c_bridge_top
FILELIST  ?= i2c_bridge_top.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TB_TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TB_TOP): $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TB_TOP) -f $(FILELIST) \
		--Mdir $(OBJ_DIR) -o V$(TB_TOP)

sim: $(OBJ_DIR)/V$(TB_TOP)
	./$(OBJ_DIR)/V$(TB_TOP) | tee /dev/stderr | grep -q "TB PASSED"

clean:
	rm -rf $(OBJ_DIR)

//--- test/tb_i2c_bridge.sv
`timescale 1ns/100ps

module tb_i2c_bridge;

  localparam logic [15:0] PRESCALE = 16'd4;
  localparam int NUM_TXN = 12;

  logic        clk;
  logic        rst;
  logic [5:0]  cmd_addr;
  logic [31:0] cmd_data;
  logic        cmd_rqst;
  logic        cmd_ack_o;
  logic [31:0] cmd_resp_data_o;
  logic        read_done_o;
  logic        en_i2c2_o;
  logic        ready_o;
  logic        missed_ack_o;
  logic        scl_t;
  logic        sda_t;
  logic        dev_pull;
  logic        exp_pull;
  logic        scl_bus;
  logic        sda_bus;
  logic [31:0] seed;
  logic [7:0]  ref_mem [0:255];
  logic [31:0] exp_q [$];

  // Wired-AND bus with pull-ups
  assign scl_bus = !scl_t;
  assign sda_bus = !(sda_t || dev_pull || exp_pull);

  i2c_bridge_top #(
    .PRESCALE     (PRESCALE),
    .PORT_EXP_ADDR(7'h20)
  ) uut (
    .clk            (clk),
    .rst            (rst),
    .cmd_addr_i     (cmd_addr),
    .cmd_data_i     (cmd_data),
    .cmd_rqst_i     (cmd_rqst),
    .cmd_ack_o      (cmd_ack_o),
    .cmd_resp_data_o(cmd_resp_data_o),
    .read_done_o    (read_done_o),
    .en_i2c2_o      (en_i2c2_o),
    .ready_o        (ready_o),
    .missed_ack_o   (missed_ack_o),
    .scl_i          (scl_bus),
    .scl_t_o        (scl_t),
    .sda_i          (sda_bus),
    .sda_t_o        (sda_t)
  );

  i2c_slave_model #(.DEV_ADDR(7'h50)) dev (
    .scl_i     (scl_bus),
    .sda_i     (sda_bus),
    .sda_pull_o(dev_pull)
  );
  i2c_slave_model #(.DEV_ADDR(7'h20)) expd (
    .scl_i     (scl_bus),
    .sda_i     (sda_bus),
    .sda_pull_o(exp_pull)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = !clk;
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  function automatic logic [31:0] make_cmd(input logic rd, input logic [6:0] dev_addr,
                                           input logic [7:0] d0, input logic [7:0] d1);
    return {7'h03, rd, 1'b0, dev_addr, d0, d1};
  endfunction

  // Expected response, four bytes from the pointer up, low byte first
  function automatic logic [31:0] ref_read(input logic [7:0] p);
    return {ref_mem[p + 8'd3], ref_mem[p + 8'd2], ref_mem[p + 8'd1], ref_mem[p]};
  endfunction

  task automatic check_val(input string name, input logic [31:0] act, input logic [31:0] exp);
    assert (act === exp) else begin
      $display("FAILED at %0t ns: %s expected %h, got %h", $time, name, exp, act);
      $display("TB FAILED");
      $fatal(1, "Value mismatch");
    end
  endtask

  task automatic check_mem();
    for (int i = 0; i < 256; i++) begin
      check_val($sformatf("slave mem[%02h]", i), {24'h0, dev.mem[i]}, {24'h0, ref_mem[i]});
    end
  endtask

  task automatic send_cmd(input logic [5:0] addr, input logic [31:0] data);
    @(posedge clk);
    #2;
    cmd_addr = addr;
    cmd_data = data;
    cmd_rqst = 1'b1;
    @(posedge clk);
    #2;
    cmd_rqst = 1'b0;
  endtask

  task automatic wait_ready();
    do @(negedge clk); while (!ready_o);
  endtask

  task automatic next_rand(output logic [31:0] r);
    seed = lcg_next(seed);
    r = seed;
  endtask

  // Compare process for read responses
  always @(negedge clk) begin
    if (!rst && read_done_o) begin
      assert (exp_q.size() != 0) else begin
        $display("Read finished with no read expected at %0t ns", $time);
        $display("TB FAILED");
        $fatal(1, "Unexpected read");
      end
      check_val("cmd_resp_data_o", cmd_resp_data_o, exp_q.pop_front());
    end
  end

  initial begin
    #(NUM_TXN * 400 * PRESCALE * 20);
    $display("Run did not finish within the expected time at %0t ns", $time);
    $display("TB FAILED");
    $fatal(1, "Watchdog");
  end

  initial begin
    logic [31:0] r1;
    logic [31:0] r2;
    logic [6:0]  filt;
    logic        ant;
    logic [31:0] fword;
    rst      = 1'b1;
    cmd_addr = 6'h00;
    cmd_data = 32'h0;
    cmd_rqst = 1'b0;
    seed     = 32'd89732;
    repeat (2) @(posedge clk);
    #2;
    rst = 1'b0;
    for (int i = 0; i < 256; i++) begin
      ref_mem[i] = dev.mem[i];
    end

    // Plain write on bus 2
    next_rand(r1);
    send_cmd(6'h3d, make_cmd(1'b0, 7'h50, r1[7:0], r1[15:8]));
    check_val("ready_o", {31'h0, ready_o}, 32'd0);
    wait_ready();
    ref_mem[r1[7:0]] = r1[15:8];
    check_mem();
    check_val("en_i2c2_o", {31'h0, en_i2c2_o}, 32'd1);

    // Read on bus 1, ack held low until done
    next_rand(r1);
    exp_q.push_back(ref_read(r1[7:0]));
    send_cmd(6'h3c, make_cmd(1'b1, 7'h50, r1[7:0], 8'h00));
    forever begin
      @(negedge clk);
      if (read_done_o) break;
      check_val("cmd_ack_o", {31'h0, cmd_ack_o}, 32'd0);
    end
    wait_ready();
    check_val("pending reads", exp_q.size(), 32'd0);
    check_val("en_i2c2_o", {31'h0, en_i2c2_o}, 32'd0);

    // Filter update, then the same values again
    next_rand(r1);
    filt  = r1[6:0] | 7'h01;
    ant   = r1[8];
    fword = {8'h00, filt, 3'b000, ant, 13'h0000};
    send_cmd(6'h00, fword);
    wait_ready();
    check_val("expander mem[0a]", {24'h0, expd.mem[8'h0a]}, {24'h0, ant, filt});
    check_val("expander mem[0b]", {24'h0, expd.mem[8'h0b]}, 32'd0);
    check_val("en_i2c2_o", {31'h0, en_i2c2_o}, 32'd1);
    send_cmd(6'h00, fword);
    repeat (200) begin
      @(negedge clk);
      check_val("scl", {31'h0, scl_bus}, 32'd1);
      check_val("sda", {31'h0, sda_bus}, 32'd1);
    end

    // Second request while busy is dropped
    next_rand(r1);
    next_rand(r2);
    send_cmd(6'h3c, make_cmd(1'b0, 7'h50, r1[7:0], r1[15:8]));
    repeat (20) @(negedge clk);
    send_cmd(6'h3c, make_cmd(1'b0, 7'h50, r1[7:0] ^ 8'h80, r2[7:0]));
    check_val("cmd_ack_o", {31'h0, cmd_ack_o}, 32'd0);
    wait_ready();
    ref_mem[r1[7:0]] = r1[15:8];
    check_mem();
    check_val("en_i2c2_o", {31'h0, en_i2c2_o}, 32'd0);

    // Absent device, then a good command
    send_cmd(6'h3d, make_cmd(1'b0, 7'h33, 8'h10, 8'h20));
    wait_ready();
    check_val("missed_ack_o", {31'h0, missed_ack_o}, 32'd1);
    check_val("en_i2c2_o", {31'h0, en_i2c2_o}, 32'd1);
    next_rand(r1);
    send_cmd(6'h3c, make_cmd(1'b0, 7'h50, r1[7:0], r1[15:8]));
    wait_ready();
    ref_mem[r1[7:0]] = r1[15:8];
    check_val("missed_ack_o", {31'h0, missed_ack_o}, 32'd0);
    check_mem();

    $display("TB PASSED");
    $finish;
  end

endmodule

//--- test/i2c_bridge_properties.sv
`timescale 1ns/100ps

module i2c_bridge_properties (
  input logic clk,
  input logic rst,
  input logic scl,
  input logic sda,
  input logic start_q,
  input logic stop_q,
  input logic run,
  input logic ready,
  input logic read_done
);

  // SDA moves with SCL high only inside a running start or stop
  sda_stable: assert property (@(posedge clk) disable iff (rst)
    (scl && $past(scl) && (sda != $past(sda))) |->
      ($past(run) && ($past(start_q) || $past(stop_q))))
    else $error("SDA changed while SCL was high outside start or stop");

  busy_not_ready: assert property (@(posedge clk) disable iff (rst)
    run |-> !ready)
    else $error("ready_o high while the byte engine runs");

  done_pulse: assert property (@(posedge clk) disable iff (rst)
    read_done |=> !read_done)
    else $error("read_done_o longer than one cycle");

endmodule

bind i2c_bridge_top i2c_bridge_properties props (
  .clk      (clk),
  .rst      (rst),
  .scl      (scl_i),
  .sda      (sda_i),
  .start_q  (u_engine.in_start_q),
  .stop_q   (u_engine.in_stop_q),
  .run      (u_engine.run_o),
  .ready    (ready_o),
  .read_done(read_done_o)
);

//--- test/i2c_slave_model.sv
`timescale 1ns/100ps

module i2c_slave_model #(
  parameter logic [6:0] DEV_ADDR = 7'h50
) (
  input  logic scl_i,
  input  logic sda_i,
  output logic sda_pull_o
);

  logic [7:0] mem [0:255];
  logic [7:0] sh;
  logic [7:0] ptr;
  logic [3:0] bit_cnt;
  logic       scl_prev;
  logic       sda_prev;
  logic       active;
  logic       first;
  logic       rw;
  logic       got_ptr;
  logic       nacked;

  initial begin
    for (int i = 0; i < 256; i++) begin
      mem[i] = i[7:0] * 8'd37 + 8'h5b;
    end
    sda_pull_o = 1'b0;
    active     = 1'b0;
    first      = 1'b0;
    rw         = 1'b0;
    got_ptr    = 1'b0;
    nacked     = 1'b0;
    bit_cnt    = 4'd0;
    sh         = 8'h00;
    ptr        = 8'h00;
    scl_prev   = 1'b1;
    sda_prev   = 1'b1;
  end

  // One process watches both lines for start, stop and SCL edges
  always @(scl_i or sda_i) begin
    if (scl_i && scl_prev && sda_prev && !sda_i) begin
      active     = 1'b1;
      first      = 1'b1;
      rw         = 1'b0;
      got_ptr    = 1'b0;
      nacked     = 1'b0;
      bit_cnt    = 4'd0;
      sda_pull_o = 1'b0;
    end else if (scl_i && scl_prev && !sda_prev && sda_i) begin
      active     = 1'b0;
      sda_pull_o = 1'b0;
    end else if (active && scl_i && !scl_prev) begin
      if (bit_cnt < 4'd8 && !(rw && !first)) begin
        sh = {sh[6:0], sda_i};
      end else if (bit_cnt == 4'd8 && rw && !first) begin
        nacked = sda_i;
      end
      bit_cnt = bit_cnt + 4'd1;
    end else if (active && !scl_i && scl_prev) begin
      if (bit_cnt == 4'd8 && !(rw && !first)) begin
        if (first) begin
          if (sh[7:1] == DEV_ADDR) begin
            rw         = sh[0];
            first      = 1'b0;
            sda_pull_o = 1'b1;
          end else begin
            active = 1'b0;
          end
        end else begin
          if (!got_ptr) begin
            ptr     = sh;
            got_ptr = 1'b1;
          end else begin
            mem[ptr] = sh;
            ptr      = ptr + 8'd1;
          end
          sda_pull_o = 1'b1;
        end
      end else if (bit_cnt == 4'd8) begin
        // Master owns the ACK slot
        sda_pull_o = 1'b0;
      end else if (bit_cnt == 4'd9) begin
        bit_cnt    = 4'd0;
        sda_pull_o = 1'b0;
        if (rw && !nacked) begin
          sh         = mem[ptr];
          ptr        = ptr + 8'd1;
          sda_pull_o = !sh[7];
        end
      end else if (rw && !first && !nacked && bit_cnt != 4'd0) begin
        sda_pull_o = !sh[3'd7 - bit_cnt[2:0]];
      end
    end
    scl_prev = scl_i;
    sda_prev = sda_i;
  end

endmodule

//--- verilog/i2c_bridge_top.sv
`timescale 1ns/100ps

module i2c_bridge_top #(
  parameter logic [15:0] PRESCALE      = 16'd4,
  parameter logic [6:0]  PORT_EXP_ADDR = 7'h20
) (
  input  logic        clk,
  input  logic        rst,
  input  logic [5:0]  cmd_addr_i,
  input  logic [31:0] cmd_data_i,
  input  logic        cmd_rqst_i,
  output logic        cmd_ack_o,
  output logic [31:0] cmd_resp_data_o,
  output logic        read_done_o,
  output logic        en_i2c2_o,
  output logic        ready_o,
  output logic        missed_ack_o,
  input  logic        scl_i,
  output logic        scl_t_o,
  input  logic        sda_i,
  output logic        sda_t_o
);

  import i2c_bridge_pkg::*;

  i2c_op_e    op;
  logic [7:0] tx_byte;
  logic       op_start;
  logic       op_done;
  logic [7:0] rx_byte;
  logic       nack;
  logic       run;
  logic       tick;

  i2c_cmd_sequencer #(
    .PORT_EXP_ADDR(PORT_EXP_ADDR)
  ) u_seq (
    .clk            (clk),
    .rst            (rst),
    .cmd_addr_i     (cmd_addr_i),
    .cmd_data_i     (cmd_data_i),
    .cmd_rqst_i     (cmd_rqst_i),
    .cmd_ack_o      (cmd_ack_o),
    .cmd_resp_data_o(cmd_resp_data_o),
    .read_done_o    (read_done_o),
    .en_i2c2_o      (en_i2c2_o),
    .ready_o        (ready_o),
    .missed_ack_o   (missed_ack_o),
    .op_o           (op),
    .tx_byte_o      (tx_byte),
    .op_start_o     (op_start),
    .op_done_i      (op_done),
    .rx_byte_i      (rx_byte),
    .nack_i         (nack)
  );

  i2c_bit_timer #(
    .PRESCALE(PRESCALE)
  ) u_timer (
    .clk   (clk),
    .rst   (rst),
    .run_i (run),
    .tick_o(tick)
  );

  // High *_t_o pulls the pin low
  i2c_byte_engine u_engine (
    .clk       (clk),
    .rst       (rst),
    .op_i      (op),
    .tx_byte_i (tx_byte),
    .op_start_i(op_start),
    .op_done_o (op_done),
    .rx_byte_o (rx_byte),
    .nack_o    (nack),
    .run_o     (run),
    .tick_i    (tick),
    .scl_i     (scl_i),
    .scl_t_o   (scl_t_o),
    .sda_i     (sda_i),
    .sda_t_o   (sda_t_o)
  );

endmodule

//--- i2c_bridge/i2c_byte_engine.sv
`timescale 1ns/100ps

module i2c_byte_engine (
  input  logic                    clk,
  input  logic                    rst,
  input  i2c_bridge_pkg::i2c_op_e op_i,
  input  logic [7:0]              tx_byte_i,
  input  logic                    op_start_i,
  output logic                    op_done_o,
  output logic [7:0]              rx_byte_o,
  output logic                    nack_o,
  output logic                    run_o,
  input  logic                    tick_i,
  input  logic                    scl_i,
  output logic                    scl_t_o,
  input  logic                    sda_i,
  output logic                    sda_t_o
);

  import i2c_bridge_pkg::*;

  logic       in_start_q;
  logic       in_stop_q;
  logic       is_tx_q;
  logic       ack_low_q;
  logic [1:0] phase_q;
  logic [3:0] bit_q;
  logic [7:0] shift_q;
  logic       sda_smp_q;
  logic       scl_low;
  logic       sda_low;
  logic       load;
  logic       last_tick;

  // Line levels for the current quarter
  always_comb begin
    scl_low = 1'b0;
    sda_low = 1'b0;
    if (in_start_q) begin
      // SDA falls while SCL is high, then SCL goes low
      sda_low = (phase_q != 2'd0);
      scl_low = (phase_q == 2'd3);
    end else if (in_stop_q) begin
      // SDA rises in the third quarter with SCL high
      scl_low = (phase_q == 2'd0);
      sda_low = (phase_q <= 2'd1);
    end else begin
      scl_low = (phase_q == 2'd0) || (phase_q == 2'd3);
      if (bit_q == 4'd8) begin
        sda_low = ack_low_q;
      end else begin
        sda_low = is_tx_q && !shift_q[7];
      end
    end
  end

  assign load = op_start_i && !run_o;
  assign last_tick = tick_i && (phase_q == 2'd3) &&
                     (in_stop_q || (!in_start_q && (bit_q == 4'd8)));

  always_ff @(posedge clk) begin
    if (rst) begin
      run_o      <= 1'b0;
      op_done_o  <= 1'b0;
      nack_o     <= 1'b0;
      in_start_q <= 1'b0;
      in_stop_q  <= 1'b0;
      phase_q    <= 2'd0;
      bit_q      <= 4'd0;
      scl_t_o    <= 1'b0;
      sda_t_o    <= 1'b0;
    end else begin
      op_done_o <= 1'b0;
      nack_o    <= 1'b0;
      // Lines hold their last level between operations
      if (run_o) begin
        scl_t_o <= scl_low;
        sda_t_o <= sda_low;
      end
      if (load) begin
        run_o      <= 1'b1;
        in_start_q <= (op_i == OP_START_WRITE);
        in_stop_q  <= (op_i == OP_STOP);
        phase_q    <= 2'd0;
        bit_q      <= 4'd0;
      end else if (run_o && tick_i) begin
        phase_q <= phase_q + 2'd1;
        if (phase_q == 2'd3) begin
          if (in_start_q) begin
            in_start_q <= 1'b0;
          end else if (!in_stop_q && (bit_q != 4'd8)) begin
            bit_q <= bit_q + 4'd1;
          end
        end
        if (last_tick) begin
          run_o     <= 1'b0;
          op_done_o <= 1'b1;
          nack_o    <= is_tx_q && sda_smp_q;
        end
      end
    end
  end

  // Sample in the third quarter, shift at the end of each data bit
  always_ff @(posedge clk) begin
    if (load) begin
      shift_q   <= tx_byte_i;
      is_tx_q   <= (op_i == OP_START_WRITE) || (op_i == OP_WRITE);
      ack_low_q <= (op_i == OP_READ_ACK);
    end else if (run_o && tick_i && !in_start_q && !in_stop_q) begin
      if ((phase_q == 2'd2) && scl_i) begin
        sda_smp_q <= sda_i;
      end
      if ((phase_q == 2'd3) && (bit_q != 4'd8)) begin
        shift_q <= {shift_q[6:0], sda_smp_q};
      end
    end
  end

  assign rx_byte_o = shift_q;

endmodule

//--- i2c_bridge/i2c_bit_timer.sv
`timescale 1ns/100ps

module i2c_bit_timer #(
  parameter logic [15:0] PRESCALE = 16'd4
) (
  input  logic clk,
  input  logic rst,
  input  logic run_i,
  output logic tick_o
);

  logic [15:0] cnt_q;

  // Counter parks at the reload value while idle, so a new count starts on run rising
  always_ff @(posedge clk) begin
    if (rst) begin
      cnt_q <= PRESCALE - 16'd1;
    end else if (!run_i || tick_o) begin
      cnt_q <= PRESCALE - 16'd1;
    end else begin
      cnt_q <= cnt_q - 16'd1;
    end
  end

  // One tick per quarter bit
  assign tick_o = run_i && (cnt_q == 16'd0);

endmodule

//--- i2c_bridge/i2c_cmd_sequencer.sv
`timescale 1ns/100ps

module i2c_cmd_sequencer #(
  parameter logic [6:0] PORT_EXP_ADDR = 7'h20
) (
  input  logic                    clk,
  input  logic                    rst,
  input  logic [5:0]              cmd_addr_i,
  input  logic [31:0]             cmd_data_i,
  input  logic                    cmd_rqst_i,
  output logic                    cmd_ack_o,
  output logic [31:0]             cmd_resp_data_o,
  output logic                    read_done_o,
  output logic                    en_i2c2_o,
  output logic                    ready_o,
  output logic                    missed_ack_o,
  output i2c_bridge_pkg::i2c_op_e op_o,
  output logic [7:0]              tx_byte_o,
  output logic                    op_start_o,
  input  logic                    op_done_i,
  input  logic [7:0]              rx_byte_i,
  input  logic                    nack_i
);

  import i2c_bridge_pkg::*;

  seq_state_e state_q;
  seq_state_e state_next;
  logic [6:0] filt_q;
  logic       ant_q;
  logic [6:0] dev_q;
  logic [7:0] d0_q;
  logic [7:0] d1_q;
  logic       three_q;
  logic [1:0] byte_cnt_q;
  logic       is_i2c;
  logic       is_filt;
  logic       need_bus;
  logic       accept;
  logic       missed;
  logic       last_byte;

  assign is_i2c = ((cmd_addr_i == ADDR_BUS1) || (cmd_addr_i == ADDR_BUS2)) &&
                  (cmd_data_i[31:25] == CMD_MAGIC);
  // Filter update goes out only when it changes the shadow
  assign is_filt = (cmd_addr_i == ADDR_FILTER) &&
                   ((cmd_data_i[23:17] != filt_q) || (cmd_data_i[13] != ant_q));
  assign need_bus  = cmd_rqst_i && (is_i2c || is_filt);
  assign accept    = need_bus && (state_q == IDLE);
  assign missed    = need_bus && (state_q != IDLE);
  assign last_byte = op_done_i && (state_q == R_BYTE) && (byte_cnt_q == 2'd3);
  assign ready_o   = (state_q == IDLE);

  always_comb begin
    state_next = state_q;
    if (accept) begin
      state_next = (is_i2c && cmd_data_i[24]) ? R_ADDR : W_ADDR;
    end else if (op_done_i) begin
      case (state_q)
        W_ADDR:  state_next = W_DATA0;
        W_DATA0: state_next = W_DATA1;
        W_DATA1: state_next = three_q ? W_DATA2 : W_STOP;
        W_DATA2: state_next = W_STOP;
        R_ADDR:  state_next = R_PTR;
        R_PTR:   state_next = R_PSTOP;
        R_PSTOP: state_next = R_RADDR;
        R_RADDR: state_next = R_BYTE;
        R_BYTE:  state_next = (byte_cnt_q == 2'd3) ? R_STOP : R_BYTE;
        default: state_next = IDLE;
      endcase
    end
  end

  // Opcode and byte for the operation of the current state
  always_comb begin
    op_o      = OP_STOP;
    tx_byte_o = 8'hff;
    case (state_q)
      W_ADDR, R_ADDR: begin
        op_o      = OP_START_WRITE;
        tx_byte_o = {dev_q, 1'b0};
      end
      R_RADDR: begin
        op_o      = OP_START_WRITE;
        tx_byte_o = {dev_q, 1'b1};
      end
      W_DATA0, R_PTR: begin
        op_o      = OP_WRITE;
        tx_byte_o = d0_q;
      end
      W_DATA1: begin
        op_o      = OP_WRITE;
        tx_byte_o = d1_q;
      end
      W_DATA2: begin
        op_o      = OP_WRITE;
        tx_byte_o = 8'h00;
      end
      R_BYTE: begin
        op_o = (byte_cnt_q == 2'd3) ? OP_READ_NACK : OP_READ_ACK;
      end
      default: begin
        op_o = OP_STOP;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q      <= IDLE;
      filt_q       <= 7'd0;
      ant_q        <= 1'b0;
      byte_cnt_q   <= 2'd0;
      op_start_o   <= 1'b0;
      read_done_o  <= 1'b0;
      missed_ack_o <= 1'b0;
      en_i2c2_o    <= 1'b0;
      cmd_ack_o    <= 1'b1;
    end else begin
      state_q     <= state_next;
      op_start_o  <= accept || (op_done_i && (state_next != IDLE));
      read_done_o <= last_byte;
      // Low for a missed request and for the whole read
      cmd_ack_o   <= !missed &&
                     !(state_next inside {R_ADDR, R_PTR, R_PSTOP, R_RADDR, R_BYTE});
      if (accept) begin
        missed_ack_o <= 1'b0;
        byte_cnt_q   <= 2'd0;
        en_i2c2_o    <= is_i2c ? (cmd_addr_i == ADDR_BUS2) : 1'b1;
        if (!is_i2c) begin
          filt_q <= cmd_data_i[23:17];
          ant_q  <= cmd_data_i[13];
        end
      end else begin
        if (nack_i) begin
          missed_ack_o <= 1'b1;
        end
        if (op_done_i && (state_q == R_BYTE)) begin
          byte_cnt_q <= byte_cnt_q + 2'd1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      three_q <= !is_i2c;
      if (is_i2c) begin
        dev_q <= cmd_data_i[22:16];
        d0_q  <= cmd_data_i[15:8];
        d1_q  <= cmd_data_i[7:0];
      end else begin
        dev_q <= PORT_EXP_ADDR;
        d0_q  <= EXP_GPIO_REG;
        d1_q  <= {cmd_data_i[13], cmd_data_i[23:17]};
      end
    end
    // Read bytes fill the response from the low byte up
    if (op_done_i && (state_q == R_BYTE)) begin
      cmd_resp_data_o[{byte_cnt_q, 3'b000} +: 8] <= rx_byte_i;
    end
  end

endmodule

//--- common/i2c_bridge_pkg.sv
package i2c_bridge_pkg;

  // Byte engine opcodes
  typedef enum logic [2:0] {
    OP_START_WRITE,
    OP_WRITE,
    OP_READ_ACK,
    OP_READ_NACK,
    OP_STOP
  } i2c_op_e;

  // Sequencer states, W_* for writes and expander updates, R_* for reads
  typedef enum logic [3:0] {
    IDLE,
    W_ADDR,
    W_DATA0,
    W_DATA1,
    W_DATA2,
    W_STOP,
    R_ADDR,
    R_PTR,
    R_PSTOP,
    R_RADDR,
    R_BYTE,
    R_STOP
  } seq_state_e;

  // Command word decoding
  localparam logic [6:0] CMD_MAGIC    = 7'h03;
  localparam logic [5:0] ADDR_BUS1    = 6'h3c;
  localparam logic [5:0] ADDR_BUS2    = 6'h3d;
  localparam logic [5:0] ADDR_FILTER  = 6'h00;
  localparam logic [7:0] EXP_GPIO_REG = 8'h0a;

endpackage
